/* Bender.yml */
package:
  name: frv_frontend

sources:
  - files:
      - hdl/frv_pkg.sv
      - hdl/frv_pipeline_register.sv
      - hdl/frv_fetch.sv
      - hdl/frv_decode.sv
      - hdl/frv_frontend.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_frv_frontend.sv

/* filelist.f */
+incdir+sim
hdl/frv_pkg.sv
hdl/frv_pipeline_register.sv
hdl/frv_fetch.sv
hdl/frv_decode.sv
hdl/frv_frontend.sv
sim/tb_frv_frontend.sv

/* hdl/frv_decode.sv */
// Combinational instruction decoder
// Sits between the fetch register and the decode register
// Handles OP, OP-IMM and LOAD, every other opcode comes out illegal
// Handshake passes straight through, decode never stalls on its own

module frv_decode import frv_pkg::*; (
    input  logic           i_valid, // Packet from the fetch register
    input  frv_fetch_pkt_t i_pkt,
    output logic           o_busy,  // Back to the fetch register

    output logic           o_valid, // Packet into the decode register
    output frv_dec_pkt_t   o_pkt,
    input  logic           i_busy
);

    frv_instr_u  instr;
    logic [31:0] imm_i; // I-type immediate, sign extended

    // Sign extend a 12-bit immediate to a full word
    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    assign instr = i_pkt.instr;
    assign imm_i = sext12(instr.i.imm12);

    always_comb begin
        // Fields common to every format
        o_pkt          = '0;
        o_pkt.pc       = i_pkt.pc;
        o_pkt.instr    = instr;
        o_pkt.rd       = instr.r.rd;
        o_pkt.rs1      = instr.r.rs1;
        o_pkt.funct3   = instr.r.funct3;

        case (instr.r.opcode)
            FRV_OPC_OP: begin
                o_pkt.op_class = OP;
                o_pkt.rs2      = instr.r.rs2;    // Second source only in R-type
                o_pkt.funct7   = instr.r.funct7;
            end
            FRV_OPC_OP_IMM: begin
                o_pkt.op_class = OP_IMM;
                o_pkt.imm      = imm_i;
            end
            FRV_OPC_LOAD: begin
                o_pkt.op_class = LOAD;
                o_pkt.imm      = imm_i;          // Address offset
            end
            default: begin
                o_pkt.op_class = ILLEGAL;
                o_pkt.illegal  = 1'b1;           // imm, rs2 and funct7 stay zero
            end
        endcase
    end

    assign o_valid = i_valid;
    assign o_busy  = i_busy; // No state, so busy is the register's busy

endmodule

/* hdl/frv_fetch.sv */
// Fetch unit of the front end
// Issues one memory request at a time and turns each response into a packet
// The program counter steps by 4 when the packet is taken downstream
// A redirect reloads the counter and discards any response still in flight

module frv_fetch import frv_pkg::*; (
    input  logic           g_clk,
    input  logic           g_resetn,

    input  logic           i_redirect,    // One-cycle strobe
    input  logic [31:0]    i_redirect_pc, // New fetch address

    output logic           o_imem_req,    // One-cycle request pulse
    output logic [31:0]    o_imem_addr,
    input  logic           i_imem_ack,    // Response strobe
    input  logic [31:0]    i_imem_rdata,

    output logic           o_valid,       // Packet held for the fetch register
    output frv_fetch_pkt_t o_pkt,
    input  logic           i_busy
);

    logic [31:0] pc;          // Address of the word being fetched
    logic        outstanding; // Request out, response not yet seen
    logic        drop;        // Next response belongs to a cancelled stream
    logic        pkt_done;
    logic        slot_free;
    logic        rsp_keep;

    assign pkt_done    = o_valid && !i_busy; // Packet taken this cycle
    // Nothing held, in flight or being issued, so another request may go
    assign slot_free   = (!o_valid || pkt_done) && !outstanding && !o_imem_req;
    assign rsp_keep    = i_imem_ack && !drop && !i_redirect;
    assign o_imem_addr = pc; // Counter only moves when no request is pending

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc          <= FRV_RESET_PC;
            o_imem_req  <= 1'b0;
            outstanding <= 1'b0;
            drop        <= 1'b0;
            o_valid     <= 1'b0;
        end else begin
            o_imem_req <= slot_free; // Pulse, slot_free drops while it is high
            if (o_imem_req) begin
                outstanding <= 1'b1;
            end else if (i_imem_ack) begin
                outstanding <= 1'b0;
            end
            if (i_redirect) begin
                pc      <= i_redirect_pc;
                o_valid <= 1'b0; // Held packet is stale
                // Request leaving now or still unanswered must be discarded
                drop    <= o_imem_req || (outstanding && !i_imem_ack);
            end else begin
                if (i_imem_ack) begin
                    drop <= 1'b0;
                end
                if (pkt_done) begin
                    o_valid <= 1'b0;
                    pc      <= pc + 32'd4;
                end else if (rsp_keep) begin
                    o_valid <= 1'b1;
                end
            end
        end
    end

    // Packet payload, pc still holds the requested address here
    always_ff @(posedge g_clk) begin
        if (rsp_keep) begin
            o_pkt.pc    <= pc;
            o_pkt.instr <= i_imem_rdata;
        end
    end

    a_one_req : assert property (
        @(posedge g_clk) disable iff (!g_resetn) o_imem_req |-> !outstanding
    ) else $error("Memory request issued while one is outstanding");

    // Memory must answer only what was asked, at least a cycle later
    a_ack_req : assert property (
        @(posedge g_clk) disable iff (!g_resetn) i_imem_ack |-> outstanding
    ) else $error("Memory acknowledge without an outstanding request");

endmodule

/* hdl/frv_frontend.sv */
// Top level of the instruction front end
// Fetch feeds a stage register, decode sits between that and a second register
// The second register faces the outside and may be stalled by i_dec_busy
// i_redirect flushes both registers and restarts fetch at i_redirect_pc

module frv_frontend import frv_pkg::*; (
    input  logic         g_clk,
    input  logic         g_resetn,

    input  logic         i_redirect,
    input  logic [31:0]  i_redirect_pc,

    output logic         o_imem_req,
    output logic [31:0]  o_imem_addr,
    input  logic         i_imem_ack,
    input  logic [31:0]  i_imem_rdata,

    output logic         o_dec_valid,
    output frv_dec_pkt_t o_dec,
    input  logic         i_dec_busy
);

    logic           f_valid;  // Fetch to fetch register
    frv_fetch_pkt_t f_pkt;
    logic           f_busy;
    logic           fr_valid; // Fetch register to decode
    frv_fetch_pkt_t fr_pkt;
    logic           fr_busy;
    logic           d_valid;  // Decode to decode register
    frv_dec_pkt_t   d_pkt;
    logic           d_busy;

    frv_fetch u_fetch (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .i_imem_ack    (i_imem_ack),
        .i_imem_rdata  (i_imem_rdata),
        .o_valid       (f_valid),
        .o_pkt         (f_pkt),
        .i_busy        (f_busy)
    );

    frv_pipeline_register #(.RLEN(FRV_FETCH_W)) u_fetch_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_data   (f_pkt),
        .i_valid  (f_valid),
        .o_busy   (f_busy),
        .i_flush  (i_redirect), // Stale fetches go on redirect
        .o_data   (fr_pkt),
        .o_valid  (fr_valid),
        .i_busy   (fr_busy)
    );

    frv_decode u_decode (
        .i_valid (fr_valid),
        .i_pkt   (fr_pkt),
        .o_busy  (fr_busy),
        .o_valid (d_valid),
        .o_pkt   (d_pkt),
        .i_busy  (d_busy)
    );

    frv_pipeline_register #(.RLEN(FRV_DEC_W)) u_dec_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_data   (d_pkt),
        .i_valid  (d_valid),
        .o_busy   (d_busy),
        .i_flush  (i_redirect),
        .o_data   (o_dec),
        .o_valid  (o_dec_valid),
        .i_busy   (i_dec_busy)  // Outside stall
    );

endmodule

/* hdl/frv_pipeline_register.sv */
// Buffered stage register between two pipeline stages
// Valid/busy handshake on both sides, a packet moves when valid and not busy
// A one-entry skid buffer catches the packet that arrives while the output stalls
// i_flush empties the output and the skid buffer in one cycle

module frv_pipeline_register #(
    parameter int RLEN = 8 // Packet width in bits
) (
    input  logic            g_clk,
    input  logic            g_resetn,

    input  logic [RLEN-1:0] i_data,  // Packet from the stage in front
    input  logic            i_valid,
    output logic            o_busy,  // Tells the stage in front to hold

    input  logic            i_flush, // Drop everything held

    output logic [RLEN-1:0] o_data,  // Packet to the stage behind
    output logic            o_valid,
    input  logic            i_busy   // Stage behind cannot take o_data
);

    logic [RLEN-1:0] b_data; // Skid buffer payload
    logic            b_full; // Skid buffer holds a packet
    logic            in_fire;
    logic            out_free;

    assign o_busy   = b_full;              // Upstream waits while the buffer is occupied
    assign in_fire  = i_valid && !o_busy;  // Packet accepted from upstream
    assign out_free = !o_valid || !i_busy; // Output may be replaced this cycle

    // Control state
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
            b_full  <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0; // Anything in flight is discarded
            b_full  <= 1'b0;
        end else if (out_free) begin
            // Buffered packet goes first, in_fire is low while it is held
            o_valid <= b_full || in_fire;
            b_full  <= 1'b0; // Buffer drains now
        end else if (in_fire) begin
            // Output stalled and a new packet arrives
            b_full  <= 1'b1; // Stop upstream until the buffer drains
        end
    end

    // Payload registers
    always_ff @(posedge g_clk) begin
        if (out_free && b_full) begin
            o_data <= b_data;
        end else if (out_free && in_fire) begin
            o_data <= i_data;   // Straight through when nothing is waiting
        end
        if (!out_free && in_fire) begin
            b_data <= i_data;   // Catch the packet that the output cannot take
        end
    end

    // Stalled output must not move
    property p_out_hold;
        @(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_busy && !i_flush |=> o_valid && $stable(o_data);
    endproperty

    a_out_hold : assert property (p_out_hold)
        else $error("Stage output changed while stalled");

    // A parked packet always sits behind a valid output
    a_busy_full : assert property (
        @(posedge g_clk) disable iff (!g_resetn) o_busy |-> o_valid
    ) else $error("Busy raised behind an empty output");

endmodule

/* hdl/frv_pkg.sv */
// Shared types and constants of the RV32 instruction front end
// Fetch, decode, the stage registers and the top level import this package
// Holds the reset address, the decoded opcodes and the packet layouts

package frv_pkg;

    // First fetch address after reset
    localparam logic [31:0] FRV_RESET_PC = 32'h0000_0000;

    // Major opcodes that the decoder understands
    localparam logic [6:0] FRV_OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] FRV_OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] FRV_OPC_LOAD   = 7'b0000011; // Loads

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } frv_r_type_t;

    // I-type view, imm12 sits where funct7 and rs2 are in R-type
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } frv_i_type_t;

    // One instruction word, read either way
    typedef union packed {
        frv_r_type_t r;
        frv_i_type_t i;
    } frv_instr_u;

    // Operation class handed on by decode
    typedef enum logic [1:0] {
        OP      = 2'd0,
        OP_IMM  = 2'd1,
        LOAD    = 2'd2,
        ILLEGAL = 2'd3 // Any opcode outside the three groups
    } frv_op_class_e;

    // Packet from fetch into the fetch register
    typedef struct packed {
        logic [31:0] pc;    // Address the word was read from
        frv_instr_u  instr; // Raw word as returned by memory
    } frv_fetch_pkt_t;

    // Packet out of decode
    typedef struct packed {
        logic [31:0]   pc;
        frv_op_class_e op_class;
        logic [4:0]    rd;
        logic [4:0]    rs1;
        logic [4:0]    rs2;     // Zero unless OP
        logic [2:0]    funct3;
        logic [6:0]    funct7;  // Zero unless OP
        logic [31:0]   imm;     // Sign extended for OP_IMM and LOAD
        logic          illegal;
        logic [31:0]   instr;   // Raw word kept for later stages
    } frv_dec_pkt_t;

    // Register widths for the two stage register instances
    localparam int FRV_FETCH_W = $bits(frv_fetch_pkt_t);
    localparam int FRV_DEC_W   = $bits(frv_dec_pkt_t);

endpackage

/* sim/frv_frontend_model.svh */
// Reference model for the front end testbench, included inside the testbench module
// Holds the 64-word instruction image and the decode reference
// The image is indexed by address bits [7:2], so fetch addresses wrap over it

`ifndef FRV_FRONTEND_MODEL_SVH
`define FRV_FRONTEND_MODEL_SVH

logic [31:0] image [0:63]; // Instruction memory seen by the responder

// Random words, roughly three in four forced into a decoded group
function automatic void fill_image();
    logic [31:0] w;
    for (int a = 0; a < 64; a++) begin
        w = $urandom;
        case ($urandom_range(0, 3))
            0: w[6:0] = FRV_OPC_OP;
            1: w[6:0] = FRV_OPC_OP_IMM;
            2: w[6:0] = FRV_OPC_LOAD;
            default: ; // Random opcode, almost always illegal
        endcase
        image[a] = w;
    end
endfunction

// Expected decode of one word, taken straight from the RV32 bit positions
function automatic frv_dec_pkt_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
    frv_dec_pkt_t d;
    d        = '0;
    d.pc     = pc;
    d.instr  = w;
    d.rd     = w[11:7];  // Always present
    d.rs1    = w[19:15];
    d.funct3 = w[14:12];
    case (w[6:0])
        FRV_OPC_OP: begin
            d.op_class = OP;
            d.rs2      = w[24:20];
            d.funct7   = w[31:25];
        end
        FRV_OPC_OP_IMM: begin
            d.op_class = OP_IMM;
            d.imm      = {{20{w[31]}}, w[31:20]};
        end
        FRV_OPC_LOAD: begin
            d.op_class = LOAD;
            d.imm      = {{20{w[31]}}, w[31:20]}; // Same I-type offset
        end
        default: begin
            d.op_class = ILLEGAL;
            d.illegal  = 1'b1;
        end
    endcase
    return d;
endfunction

`endif

/* sim/tb_frv_frontend.sv */
// Testbench for the instruction front end
// Memory responder with random latency, random output stalls and rare redirects
// Every accepted decode packet is checked against the model in the included header

module tb_frv_frontend import frv_pkg::*; ();

    localparam int NUM_PKTS       = 2000; // Accepted packets before the run ends
    localparam int REDIRECT_AFTER = 100;  // Plain sequential stream before this
    localparam int IDLE_LIMIT     = 100;  // Cycles without an accepted packet
    localparam int RUN_LIMIT      = 100000;

    logic         g_clk;
    logic         g_resetn;
    logic         i_redirect;
    logic [31:0]  i_redirect_pc;
    logic         o_imem_req;
    logic [31:0]  o_imem_addr;
    logic         i_imem_ack;
    logic [31:0]  i_imem_rdata;
    logic         o_dec_valid;
    frv_dec_pkt_t o_dec;
    logic         i_dec_busy;

    `include "frv_frontend_model.svh"

    int           accepted   = 0;
    int           redirects  = 0;
    int           fail_count = 0;
    logic [31:0]  exp_pc     = FRV_RESET_PC; // Next pc the output must carry
    logic         hold_flag  = 1'b0;         // Output was valid and stalled
    logic         mem_pending = 1'b0;        // Request taken, not yet answered
    logic [31:0]  mem_addr;
    int           mem_delay;
    logic         seen_first = 1'b0;
    logic         took;                      // Packet leaves at the coming edge

    frv_frontend DUT (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .i_imem_ack    (i_imem_ack),
        .i_imem_rdata  (i_imem_rdata),
        .o_dec_valid   (o_dec_valid),
        .o_dec         (o_dec),
        .i_dec_busy    (i_dec_busy)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    task automatic stop_on_error(input string why);
        fail_count++;
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_error("Value mismatch");
        end
    endtask

    // One request at a time, answered 1 to 3 cycles after it is seen
    task automatic memory_step();
        logic new_req;
        new_req      = o_imem_req;
        i_imem_ack   = 1'b0;
        i_imem_rdata = $urandom; // Junk between responses
        if (new_req) begin
            assert (!mem_pending) else stop_on_error("Request issued while one is pending");
        end
        if (mem_pending) begin
            mem_delay--;
            if (mem_delay == 0) begin
                i_imem_ack   = 1'b1;
                i_imem_rdata = image[mem_addr[7:2]];
                mem_pending  = 1'b0;
            end
        end
        if (new_req) begin
            if (!seen_first) begin
                compare_value("reset pc", FRV_RESET_PC, o_imem_addr); // First fetch address
                seen_first = 1'b1;
            end
            mem_pending = 1'b1;
            mem_addr    = o_imem_addr;
            mem_delay   = $urandom_range(1, 3);
        end
    endtask

    task automatic drive_step();
        i_dec_busy = ($urandom_range(0, 99) < 35);
        i_redirect = 1'b0;
        if (accepted >= REDIRECT_AFTER && $urandom_range(0, 99) == 0) begin
            i_redirect    = 1'b1;
            i_redirect_pc = $urandom & 32'h0000_0ffc; // Word aligned
            redirects++;
        end
    endtask

    // Inputs for the coming edge are already driven when this runs
    task automatic check_step();
        frv_dec_pkt_t exp;
        took = 1'b0;
        exp  = ref_decode(exp_pc, image[exp_pc[7:2]]); // Packet the output owes next
        if (hold_flag) begin
            assert (o_dec_valid === 1'b1) else stop_on_error("o_dec_valid dropped while stalled");
            compare_value("stall hold", exp, o_dec);
        end
        if (o_dec_valid && !i_dec_busy) begin
            compare_value("order pc", exp_pc, o_dec.pc);
            compare_value("decode", exp, o_dec);
            exp_pc = exp_pc + 32'd4;
            accepted++;
            took = 1'b1;
        end
        if (i_redirect) begin
            exp_pc = i_redirect_pc; // Stream restarts here
        end
        hold_flag = o_dec_valid && i_dec_busy && !i_redirect;
    endtask

    initial begin : main
        int cycles;
        int idle;
        g_resetn      = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_imem_ack    = 1'b0;
        i_imem_rdata  = '0;
        i_dec_busy    = 1'b0;
        void'($urandom(32'hede5));
        fill_image();

        repeat (10) begin
            @(negedge g_clk);
            assert (o_imem_req === 1'b0) else stop_on_error("o_imem_req high during reset");
            assert (o_dec_valid === 1'b0) else stop_on_error("o_dec_valid high during reset");
        end
        g_resetn = 1'b1;

        cycles = 0;
        idle   = 0;
        while (accepted < NUM_PKTS) begin
            @(negedge g_clk);
            memory_step();
            drive_step();
            check_step();
            idle = took ? 0 : idle + 1;
            cycles++;
            assert (idle <= IDLE_LIMIT) else stop_on_error("Output stream stopped");
            assert (cycles <= RUN_LIMIT) else stop_on_error("Run took too many cycles");
        end

        $display("Accepted %0d packets, %0d redirects", accepted, redirects);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
